// ==== sources.f ====
verilog/route_sel_pkg.sv
verilog/carry_sum_counter.sv
verilog/credit_tracker.sv
verilog/min_occupancy_finder.sv
verilog/port_decision.sv
verilog/adaptive_port_selector.sv
test/adaptive_port_selector_properties.sv
test/adaptive_port_selector_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= adaptive_port_selector_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
EXTRA     ?=

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert -Wno-fatal $(EXTRA) \
		--top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "all tests passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/adaptive_port_selector_tb.sv ====
`timescale 1ns/1ps

module adaptive_port_selector_tb;

    localparam int NUM_PORTS    = 8;
    localparam int DATA_WIDTH   = 32;
    localparam int BUFFER_DEPTH = 4;
    localparam int NUM_ROWS     = 28;
    // window in which a blocked flit must stay in the slot
    localparam int STALL_CYCLES = 12;
    localparam int TIMEOUT      = 40;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  in_valid;
    logic [DATA_WIDTH-1:0] in_data;
    logic [NUM_PORTS-1:0]  in_candidates;
    logic                  in_credit;
    logic [NUM_PORTS-1:0]  out_valid;
    logic [DATA_WIDTH-1:0] out_data;
    logic [3:0]            out_choices;
    logic [NUM_PORTS-1:0]  out_credit;
    logic                  reject;

    // stimulus table
    // ret holds the ports whose credits come back
    string                 row_name [NUM_ROWS];
    logic [NUM_PORTS-1:0]  row_mask [NUM_ROWS];
    logic [DATA_WIDTH-1:0] row_data [NUM_ROWS];
    logic [NUM_PORTS-1:0]  row_ret  [NUM_ROWS];
    int                    n_rows = 0;

    // reference copy of the downstream credits
    int model_credit [NUM_PORTS];
    int row_errors;
    int passed = 0;
    int failed = 0;

    always #2 clk = ~clk;

    adaptive_port_selector #(
        .NUM_PORTS    (NUM_PORTS),
        .DATA_WIDTH   (DATA_WIDTH),
        .BUFFER_DEPTH (BUFFER_DEPTH)
    ) u_adaptive_port_selector (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_data       (in_data),
        .in_candidates (in_candidates),
        .in_credit     (in_credit),
        .out_valid     (out_valid),
        .out_data      (out_data),
        .out_choices   (out_choices),
        .out_credit    (out_credit),
        .reject        (reject)
    );

    task automatic add_row(input string name, input logic [NUM_PORTS-1:0] mask,
                           input logic [DATA_WIDTH-1:0] data,
                           input logic [NUM_PORTS-1:0] ret);
        row_name[n_rows] = name;
        row_mask[n_rows] = mask;
        row_data[n_rows] = data;
        row_ret[n_rows]  = ret;
        n_rows++;
    endtask

    function automatic int count_bits(input logic [NUM_PORTS-1:0] v);
        int n;
        n = 0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            n += int'(v[i]);
        end
        return n;
    endfunction

    // mask with exactly the requested number of candidates
    function automatic logic [NUM_PORTS-1:0] random_mask(input int bits);
        logic [NUM_PORTS-1:0] m;
        m = '0;
        while (count_bits(m) < bits) begin
            m[$urandom % NUM_PORTS] = 1'b1;
        end
        return m;
    endfunction

    // least occupied candidate with credit
    // lowest index wins a tie
    // -1 when no candidate can take the flit
    function automatic int predict_port(input logic [NUM_PORTS-1:0] mask);
        int best;
        int best_occ;
        int occ;
        best     = -1;
        best_occ = BUFFER_DEPTH + 1;
        for (int p = 0; p < NUM_PORTS; p++) begin
            occ = BUFFER_DEPTH - model_credit[p];
            if (mask[p] && model_credit[p] > 0 && occ < best_occ) begin
                best     = p;
                best_occ = occ;
            end
        end
        return best;
    endfunction

    task automatic compare(input string name, input string what,
                           input logic [31:0] expected, input logic [31:0] actual);
        assert (expected === actual) else begin
            $display("Error %s %s: expected %0h, actual %0h", name, what, expected, actual);
            row_errors++;
        end
    endtask

    // one-cycle credit pulse from downstream
    task automatic return_credits(input logic [NUM_PORTS-1:0] ports);
        if (ports != '0) begin
            @(posedge clk);
            out_credit <= ports;
            @(posedge clk);
            out_credit <= '0;
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (ports[p] && model_credit[p] < BUFFER_DEPTH) begin
                    model_credit[p]++;
                end
            end
        end
    endtask

    task automatic report_test(input string name);
        if (row_errors == 0) begin
            passed++;
            $display("test %s: ok", name);
        end else begin
            failed++;
            $display("test %s: %0d errors", name, row_errors);
        end
    endtask

    task automatic give_up(input string why);
        $display("%s", why);
        $display("tests failed");
        $finish;
    endtask

    initial begin
        int                   cycles;
        int                   exp_port;
        int                   exp_count;
        logic [NUM_PORTS-1:0] exp_valid;
        bit                   stalled;
        void'($urandom(32'h6295a781));
        reset         = 1'b1;
        in_valid      = 1'b0;
        in_data       = '0;
        in_candidates = '0;
        out_credit    = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            model_credit[p] = BUFFER_DEPTH;
        end
        // each port once with its credit handed straight back
        for (int p = 0; p < NUM_PORTS; p++) begin
            add_row($sformatf("single_p%0d", p), NUM_PORTS'(1 << p), 32'h5100_0000 + p,
                    NUM_PORTS'(1 << p));
        end
        add_row("tie_lowest", 8'b0011_0100, 32'h1234_5678, 8'h00);
        // port 2 now holds one flit so the higher port 3 must win
        add_row("least_occupied", 8'b0000_1100, 32'h0246_8ace, 8'h00);
        // ports 2 and 3 both hold one flit
        add_row("least_occupied_tie", 8'b0000_1100, 32'h1357_9bdf, 8'b0000_1100);
        // drain port 3 so the next flit waits for a returned credit
        for (int k = 0; k < 4; k++) begin
            add_row($sformatf("fill_p3_%0d", k), 8'h08, $urandom, 8'h00);
        end
        add_row("backpressure", 8'h08, 32'h0b0b_0003, 8'h08);
        // each reject is followed by one credit back on port 3
        for (int k = 0; k < 4; k++) begin
            add_row($sformatf("empty_mask_%0d", k), 8'h00, $urandom, 8'h08);
        end
        for (int k = NUM_PORTS; k >= 1; k--) begin
            add_row($sformatf("random_%0d_candidates", k), random_mask(k), $urandom, 8'h00);
        end

        repeat (16) @(posedge clk);
        reset <= 1'b0;
        // quiet outputs straight after reset
        row_errors = 0;
        repeat (4) begin
            @(negedge clk);
            compare("reset_idle", "outputs", '0, {out_valid, reject, in_credit});
        end
        report_test("reset_idle");

        for (int r = 0; r < n_rows; r++) begin
            row_errors = 0;
            exp_count  = count_bits(row_mask[r]);
            exp_port   = predict_port(row_mask[r]);
            stalled    = (exp_count != 0) && (exp_port < 0);
            // one flit per upstream credit
            @(posedge clk);
            in_valid      <= 1'b1;
            in_data       <= row_data[r];
            in_candidates <= row_mask[r];
            @(posedge clk);
            in_valid <= 1'b0;
            cycles = 1;
            if (stalled) begin
                // no candidate has credit so the flit stays put
                repeat (STALL_CYCLES) begin
                    @(negedge clk);
                    assert (out_valid == '0 && !reject) else begin
                        $display("%s left the slot while its port had no credit",
                                 row_name[r]);
                        row_errors++;
                    end
                end
                return_credits(row_ret[r]);
                exp_port = predict_port(row_mask[r]);
            end
            @(negedge clk);
            while (out_valid == '0 && !reject) begin
                if (cycles >= TIMEOUT) begin
                    give_up($sformatf("no response to %s within %0d cycles",
                                      row_name[r], TIMEOUT));
                end
                @(posedge clk);
                cycles++;
                @(negedge clk);
            end
            exp_valid = (exp_count != 0 && exp_port >= 0) ? NUM_PORTS'(1 << exp_port) : '0;
            compare(row_name[r], "out_valid", exp_valid, out_valid);
            compare(row_name[r], "reject", exp_count == 0, reject);
            compare(row_name[r], "in_credit", 1, in_credit);
            if (exp_valid != '0) begin
                compare(row_name[r], "out_data", row_data[r], out_data);
                compare(row_name[r], "out_choices", exp_count, out_choices);
                model_credit[exp_port]--;
            end
            // sent at one edge and registered two edges later
            if (!stalled) begin
                compare(row_name[r], "latency", 2, cycles);
            end
            // results are single-cycle pulses
            @(negedge clk);
            compare(row_name[r], "pulse end", '0, {out_valid, reject, in_credit});
            if (!stalled) begin
                return_credits(row_ret[r]);
            end
            report_test(row_name[r]);
        end

        $display("summary: %0d run, %0d passed, %0d with errors", passed + failed, passed,
                 failed);
        if (failed == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== test/adaptive_port_selector_properties.sv ====
`timescale 1ns/1ps

module adaptive_port_selector_properties #(
    parameter int NUM_PORTS = 8
) (
    input logic                 clk,
    input logic                 reset,
    input logic [NUM_PORTS-1:0] out_valid,
    input logic                 reject,
    input logic                 in_credit,
    input logic [NUM_PORTS-1:0] grant,
    input logic [NUM_PORTS-1:0] has_credit
);

    // a flit leaves on one port at most
    a_out_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(out_valid))
        else $error("out_valid drives more than one port");

    // forward and reject are exclusive
    a_fwd_or_rej: assert property (@(posedge clk) disable iff (reset)
        !((|out_valid) && reject))
        else $error("out_valid and reject in the same cycle");

    // slot freed exactly once per decision
    a_slot_credit: assert property (@(posedge clk) disable iff (reset)
        in_credit == ((|out_valid) || reject))
        else $error("in_credit does not match a forward or reject");

    // never send into a full downstream buffer
    a_grant_credit: assert property (@(posedge clk) disable iff (reset)
        (grant & ~has_credit) == '0)
        else $error("grant to a port with no credit");

endmodule

bind adaptive_port_selector adaptive_port_selector_properties #(
    .NUM_PORTS (NUM_PORTS)
) u_properties (
    .clk        (clk),
    .reset      (reset),
    .out_valid  (out_valid),
    .reject     (reject),
    .in_credit  (in_credit),
    .grant      (grant),
    .has_credit (has_credit)
);

// ==== verilog/adaptive_port_selector.sv ====
`timescale 1ns/1ps

module adaptive_port_selector import route_sel_pkg::*; #(
    parameter int NUM_PORTS    = 8,
    parameter int DATA_WIDTH   = 32,
    parameter int BUFFER_DEPTH = 4
) (
    input  logic                               clk,
    input  logic                               reset,
    // upstream side
    input  logic                               in_valid,
    input  logic [DATA_WIDTH-1:0]              in_data,
    input  logic [NUM_PORTS-1:0]               in_candidates,
    output logic                               in_credit,
    // downstream side
    output logic [NUM_PORTS-1:0]               out_valid,
    output logic [DATA_WIDTH-1:0]              out_data,
    output logic [$clog2(NUM_PORTS+1)-1:0]     out_choices,
    input  logic [NUM_PORTS-1:0]               out_credit,
    output logic                               reject
);

    localparam int CNT_W = $clog2(NUM_PORTS + 1);
    localparam int OCC_W = $clog2(BUFFER_DEPTH + 1);

    generate
        if (NUM_PORTS < 2 || NUM_PORTS > MAX_PORTS) begin : g_range_check
            $error("adaptive_port_selector needs 2 to %0d ports", MAX_PORTS);
        end
    endgenerate

    logic [NUM_PORTS-1:0]             has_credit;
    logic [NUM_PORTS-1:0][OCC_W-1:0]  occupancy;
    logic [NUM_PORTS-1:0]             grant;
    logic [NUM_PORTS-1:0]             slot_candidates;
    logic [NUM_PORTS-1:0]             eligible;
    logic [CNT_W-1:0]                 candidate_count;
    logic [NUM_PORTS-1:0]             min_ports;

    // per-port downstream credits
    credit_tracker #(
        .NUM_PORTS    (NUM_PORTS),
        .BUFFER_DEPTH (BUFFER_DEPTH)
    ) u_credit_tracker (
        .clk        (clk),
        .reset      (reset),
        .grant      (grant),
        .out_credit (out_credit),
        .has_credit (has_credit),
        .occupancy  (occupancy)
    );

    // number of candidates in the slot
    carry_sum_counter #(
        .NUM_PORTS (NUM_PORTS)
    ) u_carry_sum_counter (
        .in_bits (slot_candidates),
        .count   (candidate_count)
    );

    // least occupied eligible ports
    min_occupancy_finder #(
        .NUM_PORTS    (NUM_PORTS),
        .BUFFER_DEPTH (BUFFER_DEPTH)
    ) u_min_occupancy_finder (
        .occupancy (occupancy),
        .eligible  (eligible),
        .min_ports (min_ports)
    );

    // slot FSM and output registers
    port_decision #(
        .NUM_PORTS  (NUM_PORTS),
        .DATA_WIDTH (DATA_WIDTH)
    ) u_port_decision (
        .clk             (clk),
        .reset           (reset),
        .in_valid        (in_valid),
        .in_data         (in_data),
        .in_candidates   (in_candidates),
        .has_credit      (has_credit),
        .candidate_count (candidate_count),
        .min_ports       (min_ports),
        .slot_candidates (slot_candidates),
        .eligible        (eligible),
        .grant           (grant),
        .out_valid       (out_valid),
        .out_data        (out_data),
        .out_choices     (out_choices),
        .in_credit       (in_credit),
        .reject          (reject)
    );

endmodule

// ==== verilog/port_decision.sv ====
`timescale 1ns/1ps

module port_decision import route_sel_pkg::*; #(
    parameter int NUM_PORTS  = 8,
    parameter int DATA_WIDTH = 32
) (
    input  logic                               clk,
    input  logic                               reset,
    // upstream flit
    input  logic                               in_valid,
    input  logic [DATA_WIDTH-1:0]              in_data,
    input  logic [NUM_PORTS-1:0]               in_candidates,
    // state from the tracker, counter and finder
    input  logic [NUM_PORTS-1:0]               has_credit,
    input  logic [$clog2(NUM_PORTS+1)-1:0]     candidate_count,
    input  logic [NUM_PORTS-1:0]               min_ports,
    // slot contents out to the counter and finder
    output logic [NUM_PORTS-1:0]               slot_candidates,
    output logic [NUM_PORTS-1:0]               eligible,
    output logic [NUM_PORTS-1:0]               grant,
    // registered results
    output logic [NUM_PORTS-1:0]               out_valid,
    output logic [DATA_WIDTH-1:0]              out_data,
    output logic [$clog2(NUM_PORTS+1)-1:0]     out_choices,
    output logic                               in_credit,
    output logic                               reject
);

    slot_state_t           state;
    verdict_t              verdict_next;
    verdict_t              verdict_q;
    logic                  fire_q;
    logic                  take;
    logic [DATA_WIDTH-1:0] slot_data;
    logic [NUM_PORTS-1:0]  pick;

    // candidates that can accept a flit right now
    assign eligible = slot_candidates & has_credit;

    // no candidates at all means the flit is dropped
    assign verdict_next = (candidate_count == '0) ? verdict_reject : verdict_forward;

    // slot resolves on reject or once some candidate has credit
    // otherwise the flit waits for a returned credit
    assign take = (state == slot_full) &&
                  ((verdict_next == verdict_reject) || (min_ports != '0));

    // lowest set bit of the minimum vector
    assign pick = min_ports & (~min_ports + 1'b1);

    assign grant = (take && verdict_next == verdict_forward) ? pick : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= slot_empty;
            fire_q    <= 1'b0;
            verdict_q <= verdict_forward;
            out_valid <= '0;
        end else begin
            // one-cycle pulse for each decision
            fire_q    <= take;
            out_valid <= grant;
            if (take) begin
                verdict_q <= verdict_next;
            end
            unique case (state)
                slot_empty: begin
                    if (in_valid) begin
                        state <= slot_full;
                    end
                end
                slot_full: begin
                    if (take) begin
                        state <= slot_empty;
                    end
                end
                default: state <= slot_empty;
            endcase
        end
    end

    // slot payload and output data
    always_ff @(posedge clk) begin
        if (in_valid && state == slot_empty) begin
            slot_data       <= in_data;
            slot_candidates <= in_candidates;
        end
        if (take) begin
            out_data    <= slot_data;
            out_choices <= candidate_count;
        end
    end

    // slot freed on every decision, forward or reject
    assign in_credit = fire_q;
    assign reject    = fire_q && (verdict_q == verdict_reject);

endmodule

// ==== verilog/min_occupancy_finder.sv ====
`timescale 1ns/1ps

module min_occupancy_finder #(
    parameter int NUM_PORTS    = 8,
    parameter int BUFFER_DEPTH = 4
) (
    input  logic [NUM_PORTS-1:0][$clog2(BUFFER_DEPTH+1)-1:0]    occupancy,
    input  logic [NUM_PORTS-1:0]                                eligible,
    output logic [NUM_PORTS-1:0]                                min_ports
);

    localparam int OCC_W = $clog2(BUFFER_DEPTH + 1);
    // one extra msb so an ineligible port ranks above any real value
    localparam int KEY_W = OCC_W + 1;

    logic [KEY_W-1:0]     key  [NUM_PORTS];
    // row i holds port i against all the others
    logic [NUM_PORTS-2:0] comp [NUM_PORTS];

    genvar i, j;
    generate
        for (i = 0; i < NUM_PORTS; i++) begin : g_key
            // ineligible ports look full
            assign key[i] = eligible[i] ? {1'b0, occupancy[i]} : {KEY_W{1'b1}};
        end

        for (i = 0; i < NUM_PORTS; i++) begin : g_row
            for (j = 0; j < NUM_PORTS - 1; j++) begin : g_col
                if (i > j) begin : g_lower
                    // mirror of the upper entry, strict so equal keys favour the lower port
                    assign comp[i][j] = ~(key[j] <= key[i]);
                end else begin : g_upper
                    // port i against port j+1
                    assign comp[i][j] = (key[i] <= key[j + 1]);
                end
            end
            // a port wins only if no other port beats it
            // masking keeps the result empty when nothing is eligible
            assign min_ports[i] = eligible[i] & (&comp[i]);
        end
    endgenerate

endmodule

// ==== verilog/credit_tracker.sv ====
`timescale 1ns/1ps

module credit_tracker #(
    parameter int NUM_PORTS    = 8,
    parameter int BUFFER_DEPTH = 4
) (
    input  logic                                                clk,
    input  logic                                                reset,
    // one-hot send pulse from the slot decision
    input  logic [NUM_PORTS-1:0]                                grant,
    // credit return pulses from downstream
    input  logic [NUM_PORTS-1:0]                                out_credit,
    output logic [NUM_PORTS-1:0]                                has_credit,
    output logic [NUM_PORTS-1:0][$clog2(BUFFER_DEPTH+1)-1:0]    occupancy
);

    localparam int CRED_W = $clog2(BUFFER_DEPTH + 1);
    localparam logic [CRED_W-1:0] FULL_CREDIT = CRED_W'(BUFFER_DEPTH);

    // free downstream slots per port
    logic [CRED_W-1:0] credits [NUM_PORTS];

    always_ff @(posedge clk) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (reset) begin
                // every downstream buffer starts empty
                credits[p] <= FULL_CREDIT;
            end else if (grant[p] && !out_credit[p]) begin
                // flit sent, one slot taken
                // saturate at zero so a stray grant cannot wrap
                if (credits[p] != '0) begin
                    credits[p] <= credits[p] - 1'b1;
                end
            end else if (out_credit[p] && !grant[p]) begin
                // slot freed downstream
                if (credits[p] != FULL_CREDIT) begin
                    credits[p] <= credits[p] + 1'b1;
                end
            end
            // grant and return together cancel out
        end
    end

    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            // port may take a flit while any slot is free
            has_credit[p] = (credits[p] != '0);
            // flits held downstream
            occupancy[p]  = FULL_CREDIT - credits[p];
        end
    end

endmodule

// ==== verilog/carry_sum_counter.sv ====
`timescale 1ns/1ps

module carry_sum_counter import route_sel_pkg::*; #(
    parameter int NUM_PORTS = 8
) (
    input  logic [NUM_PORTS-1:0]               in_bits,
    output logic [$clog2(NUM_PORTS+1)-1:0]     count
);

    localparam int CNT_W = $clog2(NUM_PORTS + 1);
    // pad to 7 bits for the (7,3) form, else to 15 for (15,4)
    localparam int PAD_W = (NUM_PORTS < 8) ? CS_GROUP : 2 * CS_GROUP + 1;
    localparam int PC_W  = (NUM_PORTS < 8) ? 3 : 4;

    // one carry-sum block
    // returns {a, b, c, s}, with popcount = s + 2 * (a + b + c)
    function automatic logic [3:0] cs_gen(input logic [CS_GROUP-1:0] grp);
        logic [2:0] j1;
        logic [1:0] j2;
        logic       s;
        logic       a;
        logic       b;
        logic       c;
        // low four bits and high three bits counted apart
        j1 = 3'(grp[0]) + 3'(grp[1]) + 3'(grp[2]) + 3'(grp[3]);
        j2 = 2'(grp[4]) + 2'(grp[5]) + 2'(grp[6]);
        // parity of the whole group
        s = j1[0] ^ j2[0];
        // at least two ones in each half
        a = (j1 > 3'd1);
        b = (j2 > 2'd1);
        // four ones low, or both halves odd
        c = (j1 == 3'd4) | (j1[0] & j2[0]);
        return {a, b, c, s};
    endfunction

    logic [PAD_W-1:0] padded;
    logic [PC_W-1:0]  pc_out;

    // zero extend the mask up to the block width
    assign padded = PAD_W'(in_bits);

    generate
        if (NUM_PORTS < 2 || NUM_PORTS > MAX_PORTS) begin : g_range_check
            $error("carry_sum_counter supports 2 to %0d inputs", MAX_PORTS);
        end

        if (PAD_W == CS_GROUP) begin : g_pc7
            logic [3:0] cs;
            assign cs          = cs_gen(padded);
            // sum bit is the lsb directly
            assign pc_out[0]   = cs[0];
            // carries weigh two each
            assign pc_out[2:1] = 2'(cs[3]) + 2'(cs[2]) + 2'(cs[1]);
        end else begin : g_pc15
            logic [3:0] cs0;
            logic [3:0] cs1;
            logic [3:0] cs2;
            logic [1:0] low_sum;
            // two first-stage blocks over bits 0..13
            assign cs0         = cs_gen(padded[6:0]);
            assign cs1         = cs_gen(padded[13:7]);
            // bit 14 and both sum bits give the lsb plus one more carry
            assign low_sum     = 2'(padded[14]) + 2'(cs0[0]) + 2'(cs1[0]);
            assign pc_out[0]   = low_sum[0];
            // second stage folds the seven carries, a (7,3) count
            assign cs2         = cs_gen({cs0[3:1], cs1[3:1], low_sum[1]});
            assign pc_out[1]   = cs2[0];
            assign pc_out[3:2] = 2'(cs2[3]) + 2'(cs2[2]) + 2'(cs2[1]);
        end
    endgenerate

    // upper counter bits are always zero for narrow masks
    assign count = pc_out[CNT_W-1:0];

endmodule

// ==== verilog/route_sel_pkg.sv ====
package route_sel_pkg;

    // state of the one-entry input slot
    // empty means upstream holds the credit
    typedef enum logic {
        slot_empty = 1'b0,
        slot_full  = 1'b1
    } slot_state_t;

    // outcome of one slot decision
    // forward sends the flit on the picked port
    // reject drops a flit whose candidate mask is empty
    typedef enum logic {
        verdict_forward = 1'b0,
        verdict_reject  = 1'b1
    } verdict_t;

    // input width of one carry-sum block
    // every block reduces seven bits to a sum bit and three carries
    localparam int CS_GROUP = 7;

    // widest port count the two-level counter can handle
    // (15,4) is the top form kept here
    localparam int MAX_PORTS = 15;

endpackage
